//--- ifetch.f
common/ifetch_pkg.sv
verilog/sync_ram.sv
core_ifetch/ifetch_pc_gen.sv
core_ifetch/core_ifetch.sv
verilog/ifetch_top.sv
dv/ifetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ifetch_tb \
  -Mdir obj_dir -f ifetch.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vifetch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

//--- dv/ifetch_tb.sv
module ifetch_tb;

  import ifetch_pkg::*;

  localparam logic [31:0] MEM_KEY   = 32'hC0DE_0000;
  localparam int          WALK_CYC  = 256;
  localparam int          PAIR_CYC  = 40;
  localparam int          PAIRS_RST = 4;
  localparam int          PAIRS_CA  = 120;
  localparam int          PAIRS_UC  = 60;
  localparam int          PAIRS_MIX = 160;
  localparam int          CYC_LIMIT = WALK_CYC +
                                      PAIR_CYC * (PAIRS_RST + PAIRS_CA + PAIRS_UC + PAIRS_MIX);

  logic        clk;
  logic        rst_n;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        out_ready;
  logic [1:0]  out_valid;
  logic [31:0] out_pc;
  inst_t [1:0] out_inst;
  logic        bus_valid;
  logic [31:0] bus_addr;
  logic        bus_burst;
  logic        bus_ready;
  logic        bus_rvalid;
  logic [31:0] bus_rdata;
  logic        bus_rlast;

  ifetch_top u_dut (
    .clk             (clk           ),
    .rst_n           (rst_n         ),
    .redirect_valid_i(redirect_valid),
    .redirect_pc_i   (redirect_pc   ),
    .out_ready_i     (out_ready     ),
    .out_valid_o     (out_valid     ),
    .out_pc_o        (out_pc        ),
    .out_inst_o      (out_inst      ),
    .bus_valid_o     (bus_valid     ),
    .bus_addr_o      (bus_addr      ),
    .bus_burst_o     (bus_burst     ),
    .bus_ready_i     (bus_ready     ),
    .bus_rvalid_i    (bus_rvalid    ),
    .bus_rdata_i     (bus_rdata     ),
    .bus_rlast_i     (bus_rlast     )
  );

  integer seed = 95;
  int     errors;
  int     tests;
  int     failed_tests;
  int     xfers;
  string  test_name;

  logic [31:0] exp_pc;                    // next pair the model expects
  logic        line_v [WAY_CNT][SET_CNT];
  logic [27:0] line_a [WAY_CNT][SET_CNT]; // line address, pc[31:4]
  int          victim;
  bit          first_req;

  bit          stale;                     // bus still serves a pair dropped by a redirect
  logic [31:0] stale_pc;
  bit          req_final;                 // last request of the pair's bus work
  logic [31:0] single_a;                  // last single-word address

  int          beats_left;
  logic [31:0] beat_addr;
  int          ready_wait;

  bit          held;                      // last edge stalled a valid pair
  logic [1:0]  prev_valid;
  logic [31:0] prev_pc;
  inst_t [1:0] prev_inst;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    int n;
    n = 0;
    while (n < CYC_LIMIT) begin
      @(posedge clk);
      n++;
    end
    $display("timeout: fetch did not finish within %0d cycles", CYC_LIMIT);
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  function automatic bit line_cached(input logic [31:0] addr);
    bit found;
    found = 1'b0;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (line_v[w][addr[11:4]] && line_a[w][addr[11:4]] == addr[31:4]) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("error in %s: %s", test_name, what);
      errors++;
    end
  endtask

  // targets mostly near a few lines spread over four tags, so sets conflict
  task automatic pick_target(input int mode, output logic [31:0] tgt);
    logic [31:0] page;
    page = $random(seed) & 3;
    tgt  = ((page + 1) << 12) | ($random(seed) & 32'h3C);
    if (($random(seed) & 7) == 0) begin
      tgt = $random(seed) & 32'h7FFF_FFFC;
    end
    if (mode == 2 || (mode == 3 && ($random(seed) & 1) != 0)) begin
      tgt[31] = 1'b1;
    end
  endtask

  task automatic check_pair();
    logic [31:0] a;
    check_val("pc", exp_pc, out_pc);
    check_val("valid", 32'({1'b1, !exp_pc[2]}), 32'(out_valid));
    for (int s = 0; s < 2; s++) begin
      a = {out_pc[31:3], 3'b000} + 32'(4 * s);
      if (out_valid[s]) begin
        check_val(s == 0 ? "word 0" : "word 1", mem_word(a), out_inst[s]);
      end
    end
    if (!out_pc[31]) begin
      check_true(line_cached(out_pc), "cached pair delivered without a refill of its line");
    end
    exp_pc = {exp_pc[31:3], 3'b000} + 32'd8;
  endtask

  task automatic check_request();
    logic [31:0] ref_pc;
    logic [31:0] exp_a;
    ref_pc = stale ? stale_pc : exp_pc;
    if (first_req) begin
      check_true(bus_burst && bus_addr == RESET_PC, "first fetch after reset was not a refill");
      first_req = 1'b0;
    end
    if (bus_burst) begin
      exp_a = {ref_pc[31:4], 4'h0};
      check_true(!ref_pc[31], "burst request for an uncached pair");
      check_val("burst addr", exp_a, bus_addr);
      check_true(!line_cached(exp_a), "refill requested for a line that is still cached");
      line_v[victim][exp_a[11:4]] = 1'b1;
      line_a[victim][exp_a[11:4]] = exp_a[31:4];
      victim     = (victim + 1) % WAY_CNT;
      beats_left = LINE_WORDS;
    end else begin
      // slot 0 first unless invalid or already fetched
      exp_a    = {ref_pc[31:3], 3'b000};
      exp_a[2] = ref_pc[2] || single_a == exp_a;
      check_true(ref_pc[31], "single-word request for a cached pair");
      check_val("single addr", exp_a, bus_addr);
      single_a   = exp_a;
      beats_left = 1;
    end
    req_final  = bus_burst || exp_a[2];
    beat_addr  = bus_addr;
    ready_wait = $random(seed) & 3;
  endtask

  // one cycle: drive inputs at the falling edge, model the coming rising edge
  task automatic step(input int mode);
    logic [31:0] tgt;
    @(negedge clk);
    if (held) begin
      check_val("held valid", 32'(prev_valid), 32'(out_valid));
      check_val("held pc", prev_pc, out_pc);
      check_val("held word 0", prev_inst[0], out_inst[0]);
      check_val("held word 1", prev_inst[1], out_inst[1]);
    end
    out_ready      = (mode == 0) || (($random(seed) & 3) != 0);
    redirect_valid = 1'b0;
    if (mode != 0 && ($random(seed) & 15) == 0) begin
      pick_target(mode, tgt);
      redirect_valid = 1'b1;
      redirect_pc    = tgt;
    end
    bus_ready  = 1'b0;
    bus_rvalid = 1'b0;
    bus_rlast  = 1'b0;
    if (beats_left > 0) begin
      if (($random(seed) & 3) != 0) begin // random gaps between beats
        bus_rvalid = 1'b1;
        bus_rdata  = mem_word(beat_addr);
        bus_rlast  = (beats_left == 1);
      end
    end else if (bus_valid) begin
      if (ready_wait == 0) begin
        bus_ready = 1'b1;
      end else begin
        ready_wait--;
      end
    end
    if (|out_valid && out_ready) begin
      check_pair();
      xfers++;
    end
    if (redirect_valid) begin
      if ((bus_valid || beats_left > 0) && !stale) begin
        stale    = 1'b1; // pair on the bus finishes and is dropped
        stale_pc = exp_pc;
      end
      exp_pc = redirect_pc;
    end
    if (bus_valid && bus_ready) begin
      check_request();
    end
    if (bus_rvalid) begin
      beats_left--;
      beat_addr = beat_addr + 32'd4;
      if (beats_left == 0 && req_final) begin
        stale = 1'b0;
      end
    end
    held       = |out_valid && !out_ready && !redirect_valid;
    prev_valid = out_valid;
    prev_pc    = out_pc;
    prev_inst  = out_inst;
  endtask

  task automatic report(input string name, input int pairs, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s: %0d pairs, ok", name, pairs);
    end else begin
      failed_tests++;
      $display("test %s: %0d pairs, %0d errors", name, pairs, errors - err0);
    end
  endtask

  task automatic run_test(input string name, input int mode, input int pairs);
    int err0;
    test_name = name;
    err0      = errors;
    xfers     = 0;
    while (xfers < pairs) begin
      step(mode);
    end
    report(name, pairs, err0);
  endtask

  task automatic reset_walk_test();
    int err0;
    test_name = "reset_walk";
    err0      = errors;
    xfers     = 0;
    repeat (WALK_CYC) begin
      step(0);
      check_val("valid during walk", 32'd0, 32'(out_valid));
      check_true(!bus_valid, "bus request during the tag walk");
    end
    first_req = 1'b1;
    while (xfers < PAIRS_RST) begin
      step(0);
    end
    check_true(!first_req, "no bus request after the tag walk");
    report("reset_walk", PAIRS_RST, err0);
  endtask

  initial begin
    rst_n          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    bus_ready      = 1'b0;
    bus_rvalid     = 1'b0;
    bus_rdata      = '0;
    bus_rlast      = 1'b0;
    errors         = 0;
    tests          = 0;
    failed_tests   = 0;
    exp_pc         = RESET_PC;
    victim         = 0;
    first_req      = 1'b0;
    stale          = 1'b0;
    stale_pc       = '0;
    req_final      = 1'b0;
    single_a       = 32'hFFFF_FFFF;
    beats_left     = 0;
    beat_addr      = '0;
    ready_wait     = 0;
    held           = 1'b0;
    for (int w = 0; w < WAY_CNT; w++) begin
      for (int s = 0; s < SET_CNT; s++) begin
        line_v[w][s] = 1'b0;
        line_a[w][s] = '0;
      end
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    reset_walk_test();
    run_test("cached", 1, PAIRS_CA);
    run_test("uncached", 2, PAIRS_UC);
    run_test("mixed", 3, PAIRS_MIX);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog/ifetch_top.sv
module ifetch_top (
  input  logic                    clk             ,
  input  logic                    rst_n           ,
  input  logic                    redirect_valid_i,
  input  logic [31:0]             redirect_pc_i   ,
  input  logic                    out_ready_i     ,
  output logic [1:0]              out_valid_o     ,
  output logic [31:0]             out_pc_o        ,
  output ifetch_pkg::inst_t [1:0] out_inst_o      ,
  output logic                    bus_valid_o     ,
  output logic [31:0]             bus_addr_o      ,
  output logic                    bus_burst_o     ,
  input  logic                    bus_ready_i     ,
  input  logic                    bus_rvalid_i    ,
  input  logic [31:0]             bus_rdata_i     ,
  input  logic                    bus_rlast_i
);

  logic [31:0] f1_pc;
  logic [1:0]  f1_valid;
  logic        f1_uncached;
  logic        f2_stall_req;
  logic        f2_stall;

  assign f2_stall = f2_stall_req | !out_ready_i; // freeze F1 and F2 together

  ifetch_pc_gen u_pc_gen (
    .clk             (clk             ),
    .rst_n           (rst_n           ),
    .stall_i         (f2_stall        ),
    .redirect_valid_i(redirect_valid_i),
    .redirect_pc_i   (redirect_pc_i   ),
    .pc_o            (f1_pc           ),
    .valid_o         (f1_valid        ),
    .uncached_o      (f1_uncached     )
  );

  core_ifetch u_f2 (
    .clk          (clk             ),
    .rst_n        (rst_n           ),
    .flush_i      (redirect_valid_i),
    .stall_i      (f2_stall        ),
    .f1_pc_i      (f1_pc           ),
    .f1_valid_i   (f1_valid        ),
    .f1_uncached_i(f1_uncached     ),
    .valid_o      (out_valid_o     ),
    .pc_o         (out_pc_o        ),
    .inst_o       (out_inst_o      ),
    .stall_req_o  (f2_stall_req    ),
    .bus_valid_o  (bus_valid_o     ),
    .bus_addr_o   (bus_addr_o      ),
    .bus_burst_o  (bus_burst_o     ),
    .bus_ready_i  (bus_ready_i     ),
    .bus_rvalid_i (bus_rvalid_i    ),
    .bus_rdata_i  (bus_rdata_i     ),
    .bus_rlast_i  (bus_rlast_i     )
  );

endmodule

//--- core_ifetch/core_ifetch.sv
module core_ifetch (
  input  logic                     clk          ,
  input  logic                     rst_n        ,
  input  logic                     flush_i      ,
  input  logic                     stall_i      ,
  input  logic [31:0]              f1_pc_i      ,
  input  logic [1:0]               f1_valid_i   ,
  input  logic                     f1_uncached_i,
  output logic [1:0]               valid_o      ,
  output logic [31:0]              pc_o         ,
  output ifetch_pkg::inst_t [1:0]  inst_o       ,
  output logic                     stall_req_o  ,
  output logic                     bus_valid_o  ,
  output logic [31:0]              bus_addr_o   ,
  output logic                     bus_burst_o  ,
  input  logic                     bus_ready_i  ,
  input  logic                     bus_rvalid_i ,
  input  logic [31:0]              bus_rdata_i  ,
  input  logic                     bus_rlast_i
);

  import ifetch_pkg::*;

  typedef enum logic [2:0] {
    S_NORMAL,
    S_WAITBUS, // one settle cycle after a refill
    S_RFADDR,
    S_RFDATA,
    S_UADDR0,
    S_UDATA0,
    S_UADDR1,
    S_UDATA1
  } fsm_e;

  fsm_e fsm_q;
  fsm_e fsm_d;

  logic [1:0]  fetch_v_q;
  logic [31:0] pc_q;
  logic        uncached_q;
  logic        use_skid_q; // outputs come from skid_q
  logic        kill_q;     // pair flushed while on the bus
  inst_t [1:0] skid_q;

  logic               walk_q;
  logic [IDX_LEN-1:0] walk_idx_q;

  logic [BEAT_LEN-1:0] beat_q;
  logic [WAY_CNT-1:0]  repl_q;

  itag_t [WAY_CNT-1:0]      tag_rdata;
  inst_t [WAY_CNT-1:0][1:0] bank_rdata;
  logic  [WAY_CNT-1:0]      tag_we;
  logic  [WAY_CNT-1:0]      bank_we;
  logic  [IDX_LEN-1:0]      tag_waddr;
  itag_t                    tag_wdata;
  logic  [IDX_LEN+BEAT_LEN-2:0] bank_waddr;

  logic [WAY_CNT-1:0] hit;
  inst_t [1:0]        hit_inst;
  logic               need_bus;
  logic               bus_done;
  logic               out_ok;

  // tag clear after reset, one set per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      walk_q     <= 1'b1;
      walk_idx_q <= '0;
    end else if (walk_q) begin
      walk_idx_q <= walk_idx_q + 1'b1;
      walk_q     <= !(&walk_idx_q);
    end
  end

  assign tag_we    = walk_q ? '1 : ((fsm_q == S_RFADDR) ? repl_q : '0);
  assign tag_waddr = walk_q ? walk_idx_q : pc_q[OFS_LEN +: IDX_LEN];

  always_comb begin
    tag_wdata.valid = !walk_q;
    tag_wdata.tag   = pc_q[31 -: TAG_LEN];
  end

  // refill beats go straight into the victim way
  assign bank_we    = (fsm_q == S_RFDATA && bus_rvalid_i) ? repl_q : '0;
  assign bank_waddr = {pc_q[OFS_LEN +: IDX_LEN], beat_q[BEAT_LEN-1:1]};

  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    sync_ram #(
      .T    (itag_t ),
      .DEPTH(SET_CNT)
    ) u_tag (
      .clk    (clk                          ),
      .we_i   (tag_we[w]                    ),
      .waddr_i(tag_waddr                    ),
      .wdata_i(tag_wdata                    ),
      .raddr_i(f1_pc_i[OFS_LEN +: IDX_LEN]  ),
      .rdata_o(tag_rdata[w]                 )
    );

    for (genvar b = 0; b < 2; b++) begin : g_bank
      sync_ram #(
        .T    (inst_t    ),
        .DEPTH(BANK_DEPTH)
      ) u_bank (
        .clk    (clk                                ),
        .we_i   (bank_we[w] && (beat_q[0] == 1'(b)) ),
        .waddr_i(bank_waddr                         ),
        .wdata_i(bus_rdata_i                        ),
        .raddr_i(f1_pc_i[OFS_LEN+IDX_LEN-1:3]       ),
        .rdata_o(bank_rdata[w][b]                   )
      );
    end

    assign hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == pc_q[31 -: TAG_LEN]);
  end

  always_comb begin
    hit_inst = '0;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (hit[w]) begin
        hit_inst = hit_inst | bank_rdata[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || fsm_q == S_RFADDR) begin
      beat_q <= '0;
    end else if (fsm_q == S_RFDATA && bus_rvalid_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // victim way advances once per refill
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      repl_q <= WAY_CNT'(1);
    end else if (fsm_q == S_WAITBUS) begin
      repl_q <= {repl_q[WAY_CNT-2:0], repl_q[WAY_CNT-1]};
    end
  end

  assign need_bus = |fetch_v_q && !use_skid_q && (uncached_q || !(|hit));

  always_comb begin
    fsm_d = fsm_q;
    unique case (fsm_q)
      S_NORMAL: begin
        if (need_bus && !flush_i && !walk_q) begin
          if (!uncached_q) begin
            fsm_d = S_RFADDR;
          end else if (fetch_v_q[0]) begin
            fsm_d = S_UADDR0;
          end else begin
            fsm_d = S_UADDR1;
          end
        end
      end
      S_WAITBUS: fsm_d = S_NORMAL;
      S_RFADDR: begin
        if (bus_ready_i) fsm_d = S_RFDATA;
      end
      S_RFDATA: begin
        if (bus_rvalid_i && bus_rlast_i) fsm_d = S_WAITBUS;
      end
      S_UADDR0: begin
        if (bus_ready_i) fsm_d = S_UDATA0;
      end
      S_UDATA0: begin
        if (bus_rvalid_i && bus_rlast_i) begin
          fsm_d = fetch_v_q[1] ? S_UADDR1 : S_NORMAL;
        end
      end
      S_UADDR1: begin
        if (bus_ready_i) fsm_d = S_UDATA1;
      end
      S_UDATA1: begin
        if (bus_rvalid_i && bus_rlast_i) fsm_d = S_NORMAL;
      end
      default: fsm_d = S_NORMAL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q <= S_NORMAL;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  assign bus_done = (fsm_q != S_NORMAL) && (fsm_d == S_NORMAL);

  // F2 stage control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_v_q  <= '0;
      use_skid_q <= 1'b0;
      kill_q     <= 1'b0;
    end else if (flush_i && fsm_q == S_NORMAL) begin
      fetch_v_q  <= '0;
      use_skid_q <= 1'b0;
      kill_q     <= 1'b0;
    end else if (!stall_i) begin
      fetch_v_q  <= f1_valid_i;
      use_skid_q <= 1'b0;
      kill_q     <= 1'b0;
    end else if (bus_done) begin
      if (kill_q || flush_i) begin
        fetch_v_q <= '0; // result thrown away
      end
      use_skid_q <= 1'b1;
      kill_q     <= 1'b0;
    end else begin
      if (flush_i) kill_q <= 1'b1;
      if (|valid_o) use_skid_q <= 1'b1; // held hit pair
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_q       <= f1_pc_i;
      uncached_q <= f1_uncached_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_q == S_UDATA0 && bus_rvalid_i) begin
      skid_q[0] <= bus_rdata_i;
    end else if (fsm_q == S_UDATA1 && bus_rvalid_i) begin
      skid_q[1] <= bus_rdata_i;
    end else if (fsm_q == S_RFDATA && bus_rvalid_i && beat_q[BEAT_LEN-1] == pc_q[3]) begin
      skid_q[beat_q[0]] <= bus_rdata_i; // beat belongs to the current pair
    end else if (stall_i && !use_skid_q && |valid_o) begin
      skid_q <= hit_inst;
    end
  end

  assign out_ok      = (fsm_q == S_NORMAL) && !walk_q && !need_bus;
  assign valid_o     = out_ok ? fetch_v_q : 2'b00;
  assign pc_o        = pc_q;
  assign inst_o      = use_skid_q ? skid_q : hit_inst;
  assign stall_req_o = walk_q || (fsm_q != S_NORMAL) || need_bus;

  // bus request
  assign bus_valid_o = (fsm_q == S_RFADDR) || (fsm_q == S_UADDR0) || (fsm_q == S_UADDR1);
  assign bus_burst_o = (fsm_q == S_RFADDR);

  always_comb begin
    if (fsm_q == S_RFADDR) begin
      bus_addr_o = {pc_q[31:OFS_LEN], {OFS_LEN{1'b0}}}; // line aligned
    end else if (fsm_q == S_UADDR1) begin
      bus_addr_o = {pc_q[31:3], 3'b100};
    end else begin
      bus_addr_o = {pc_q[31:3], 3'b000};
    end
  end

endmodule

//--- core_ifetch/ifetch_pc_gen.sv
module ifetch_pc_gen (
  input  logic        clk             ,
  input  logic        rst_n           ,
  input  logic        stall_i         ,
  input  logic        redirect_valid_i,
  input  logic [31:0] redirect_pc_i   ,
  output logic [31:0] pc_o            ,
  output logic [1:0]  valid_o         ,
  output logic        uncached_o
);

  import ifetch_pkg::*;

  logic [31:0] pc_q;
  logic        pend_q;    // redirect seen while stalled
  logic [31:0] pend_pc_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q   <= RESET_PC;
      pend_q <= 1'b0;
    end else if (!stall_i) begin
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end else if (pend_q) begin
        pc_q <= pend_pc_q;
      end else begin
        pc_q <= {pc_q[31:3], 3'b000} + 32'd8; // next pair
      end
      pend_q <= 1'b0;
    end else if (redirect_valid_i) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_i && redirect_valid_i) begin
      pend_pc_q <= redirect_pc_i;
    end
  end

  // nothing valid until a held redirect is taken
  assign valid_o    = pend_q ? 2'b00 : {1'b1, !pc_q[2]};
  assign pc_o       = pc_q;
  assign uncached_o = pc_q[31];

endmodule

//--- verilog/sync_ram.sv
module sync_ram #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 256
) (
  input  logic                     clk     ,
  input  logic                     we_i    ,
  input  logic [$clog2(DEPTH)-1:0] waddr_i ,
  input  T                         wdata_i ,
  input  logic [$clog2(DEPTH)-1:0] raddr_i ,
  output T                         rdata_o
);

  T mem [DEPTH];

  // a read of the address being written returns the old entry
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];
  end

endmodule

//--- common/ifetch_pkg.sv
package ifetch_pkg;

  localparam int WAY_CNT    = 2;
  localparam int SET_CNT    = 256;
  localparam int LINE_WORDS = 4;    // also the refill burst length

  // address fields of a fetch PC
  localparam int BEAT_LEN   = $clog2(LINE_WORDS);     // word within a line
  localparam int OFS_LEN    = BEAT_LEN + 2;           // bits 3:0
  localparam int IDX_LEN    = $clog2(SET_CNT);        // bits 11:4
  localparam int TAG_LEN    = 32 - IDX_LEN - OFS_LEN; // bits 31:12

  // each way keeps even and odd words in separate banks
  localparam int BANK_DEPTH = SET_CNT * LINE_WORDS / 2;

  localparam logic [31:0] RESET_PC = 32'h0000_1000;

  typedef logic [31:0] inst_t;

  typedef struct packed {
    logic               valid;
    logic [TAG_LEN-1:0] tag;
  } itag_t;

endpackage
